// File: rtl/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // fetch side widths
    ////////////////////////////////////////////////////////////////////////////

    // byte address seen by the program counter
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] inst_t;

    // boot rom entry, first fetch after reset
    localparam addr_t reset_vector = 32'hbfc00000;

    ////////////////////////////////////////////////////////////////////////////
    // fetch result handed to decode
    ////////////////////////////////////////////////////////////////////////////

    // valid is the cache hit for the current pc
    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
    } fetch_out_t;

endpackage

// File: rtl/axi_read_pkg.sv
package axi_read_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // read channel field widths
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [3:0] axi_id_t;
    // beats minus one
    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;
    typedef logic [1:0] axi_resp_t;

    // encodings used by fetch
    localparam axi_burst_t burst_incr = 2'b01;
    localparam axi_size_t  size_word  = 3'b010;
    localparam axi_id_t    fetch_id   = 4'h0;

    ////////////////////////////////////////////////////////////////////////////
    // channel bundles
    ////////////////////////////////////////////////////////////////////////////

    // read address, master to slave
    typedef struct packed {
        logic             valid;
        axi_id_t          id;
        fetch_pkg::addr_t addr;
        axi_len_t         len;
        axi_size_t        size;
        axi_burst_t       burst;
    } ar_req_t;

    // read data beat, slave to master
    typedef struct packed {
        logic        valid;
        axi_id_t     id;
        logic [31:0] data;
        axi_resp_t   resp;
        logic        last;
    } r_beat_t;

endpackage

// File: rtl/pc_sequencer.sv
`timescale 1ns/1ps

module pc_sequencer (
    input  logic             aclk,
    input  logic             rst,
    input  logic             hold,
    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             hit,
    output fetch_pkg::addr_t pc
);

    fetch_pkg::addr_t pc_next;
    logic             pc_load;

    ////////////////////////////////////////////////////////////////////////////
    // next pc select
    ////////////////////////////////////////////////////////////////////////////

    // redirect target first, sequential otherwise
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    // a miss or a hold freezes the pc, a redirect always lands
    assign pc_load = redirect | (hit & ~hold);

    ////////////////////////////////////////////////////////////////////////////
    // pc register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            pc <= fetch_pkg::reset_vector;
        end else if (pc_load) begin
            pc <= pc_next;
        end
    end

endmodule

// File: rtl/inst_cache.sv
`timescale 1ns/1ps

module inst_cache #(
    parameter int line_words = 4,
    parameter int sets       = 16
) (
    input  logic                          aclk,
    input  logic                          rst,
    input  fetch_pkg::addr_t              pc,
    output logic                          hit,
    output fetch_pkg::fetch_out_t         fetch,
    output fetch_pkg::addr_t              miss_addr,
    input  logic                          beat_take,
    input  logic [$clog2(line_words)-1:0] word_idx,
    input  fetch_pkg::inst_t              beat_data,
    input  logic                          fill_we
);

    localparam int off_bits = $clog2(line_words);
    localparam int idx_bits = $clog2(sets);
    localparam int line_lsb = off_bits + 2;
    localparam int tag_bits = 32 - idx_bits - line_lsb;

    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [idx_bits-1:0] idx_t;
    typedef logic [off_bits-1:0] off_t;

    // tag, valid and data arrays
    logic [sets-1:0]  valid_q;
    tag_t             tag_mem  [sets];
    fetch_pkg::inst_t data_mem [sets][line_words];

    // line being collected from the bus
    fetch_pkg::inst_t line_buf [line_words];
    fetch_pkg::addr_t fill_addr_q;
    logic             fill_pend_q;

    tag_t pc_tag;
    idx_t pc_idx;
    off_t pc_off;
    idx_t fill_idx;

    ////////////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////////////

    assign pc_tag   = pc[31 -: tag_bits];
    assign pc_idx   = pc[line_lsb +: idx_bits];
    assign pc_off   = pc[2 +: off_bits];
    assign fill_idx = fill_addr_q[line_lsb +: idx_bits];

    assign hit       = valid_q[pc_idx] && (tag_mem[pc_idx] == pc_tag);
    assign miss_addr = {pc[31:line_lsb], {line_lsb{1'b0}}};

    assign fetch.valid = hit;
    assign fetch.pc    = pc;
    assign fetch.inst  = data_mem[pc_idx][pc_off];

    ////////////////////////////////////////////////////////////////////////////
    // refill
    ////////////////////////////////////////////////////////////////////////////

    // follows the refill controller, which leaves idle on the same miss
    always_ff @(posedge aclk) begin
        if (rst) begin
            fill_pend_q <= 1'b0;
            valid_q     <= '0;
        end else if (fill_we) begin
            fill_pend_q       <= 1'b0;
            valid_q[fill_idx] <= 1'b1;
        end else if (!hit && !fill_pend_q) begin
            fill_pend_q <= 1'b1;
        end
    end

    // target line, kept even if the pc is redirected meanwhile
    always_ff @(posedge aclk) begin
        if (!hit && !fill_pend_q) begin
            fill_addr_q <= miss_addr;
        end
        if (beat_take) begin
            line_buf[word_idx] <= beat_data;
        end
        if (fill_we) begin
            tag_mem[fill_idx]  <= fill_addr_q[31 -: tag_bits];
            data_mem[fill_idx] <= line_buf;
        end
    end

endmodule

// File: rtl/refill_fsm.sv
`timescale 1ns/1ps

module refill_fsm #(
    parameter int line_words = 4
) (
    input  logic                  aclk,
    input  logic                  rst,
    input  logic                  hit,
    input  fetch_pkg::addr_t      miss_addr,
    output axi_read_pkg::ar_req_t ar_req,
    input  logic                  arready,
    input  axi_read_pkg::r_beat_t r_beat,
    output logic                  rready,
    output logic                  beat_take,
    output logic                  fill_we,
    output logic                  busy,
    input  logic                  burst_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data,
        st_fill
    } state_t;

    state_t           state_q;
    state_t           state_d;
    fetch_pkg::addr_t line_addr_q;

    ////////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: if (!hit) state_d = st_addr;
            st_addr: if (arready) state_d = st_data;
            // burst length comes from the beat count, not rlast
            st_data: if (burst_done) state_d = st_fill;
            st_fill: state_d = st_idle;
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // capture the missed line as the fsm leaves idle
    always_ff @(posedge aclk) begin
        if (state_q == st_idle && !hit) begin
            line_addr_q <= miss_addr;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // bus and fill controls
    ////////////////////////////////////////////////////////////////////////////

    assign ar_req.valid = (state_q == st_addr);
    assign ar_req.id    = axi_read_pkg::fetch_id;
    assign ar_req.addr  = line_addr_q;
    assign ar_req.len   = axi_read_pkg::axi_len_t'(line_words - 1);
    assign ar_req.size  = axi_read_pkg::size_word;
    assign ar_req.burst = axi_read_pkg::burst_incr;

    assign rready    = (state_q == st_data);
    assign beat_take = rready & r_beat.valid;
    assign fill_we   = (state_q == st_fill);
    assign busy      = (state_q != st_idle);

endmodule

// File: rtl/beat_counter.sv
`timescale 1ns/1ps

module beat_counter #(
    parameter int line_words = 4
) (
    input  logic                          aclk,
    input  logic                          rst,
    input  logic                          busy,
    input  logic                          beat_take,
    output logic [$clog2(line_words)-1:0] word_idx,
    output logic                          burst_done
);

    typedef logic [$clog2(line_words)-1:0] beat_idx_t;

    localparam beat_idx_t last_beat = beat_idx_t'(line_words - 1);

    beat_idx_t count_q;

    // cleared between bursts
    always_ff @(posedge aclk) begin
        if (rst || !busy) begin
            count_q <= '0;
        end else if (beat_take) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign word_idx   = count_q;
    assign burst_done = beat_take && (count_q == last_beat);

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int line_words = 4,
    parameter int sets       = 16
) (
    input  logic                   aclk,
    input  logic                   rst,
    input  logic                   hold,
    input  logic                   redirect,
    input  fetch_pkg::addr_t       redirect_pc,
    output fetch_pkg::fetch_out_t  fetch,
    output axi_read_pkg::ar_req_t  ar_req,
    input  logic                   arready,
    input  axi_read_pkg::r_beat_t  r_beat,
    output logic                   rready
);

    fetch_pkg::addr_t              pc;
    fetch_pkg::addr_t              miss_addr;
    logic                          hit;
    logic                          beat_take;
    logic                          fill_we;
    logic                          busy;
    logic                          burst_done;
    logic [$clog2(line_words)-1:0] word_idx;

    pc_sequencer u_pc (
        .aclk        (aclk),
        .rst         (rst),
        .hold        (hold),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .hit         (hit),
        .pc          (pc)
    );

    inst_cache #(
        .line_words (line_words),
        .sets       (sets)
    ) u_cache (
        .aclk       (aclk),
        .rst        (rst),
        .pc         (pc),
        .hit        (hit),
        .fetch      (fetch),
        .miss_addr  (miss_addr),
        .beat_take  (beat_take),
        .word_idx   (word_idx),
        .beat_data  (r_beat.data),
        .fill_we    (fill_we)
    );

    refill_fsm #(
        .line_words (line_words)
    ) u_refill (
        .aclk       (aclk),
        .rst        (rst),
        .hit        (hit),
        .miss_addr  (miss_addr),
        .ar_req     (ar_req),
        .arready    (arready),
        .r_beat     (r_beat),
        .rready     (rready),
        .beat_take  (beat_take),
        .fill_we    (fill_we),
        .busy       (busy),
        .burst_done (burst_done)
    );

    beat_counter #(
        .line_words (line_words)
    ) u_beats (
        .aclk       (aclk),
        .rst        (rst),
        .busy       (busy),
        .beat_take  (beat_take),
        .word_idx   (word_idx),
        .burst_done (burst_done)
    );

endmodule

// File: test/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model #(
    parameter logic [31:0] seed = 32'hcda312be
) (
    input  logic                  aclk,
    input  logic                  rst,
    input  axi_read_pkg::ar_req_t ar_req,
    output logic                  arready,
    output axi_read_pkg::r_beat_t r_beat,
    input  logic                  rready
);

    logic [31:0]           lcg_state;
    fetch_pkg::addr_t      burst_addr;
    axi_read_pkg::axi_id_t burst_id;

    // lcg step, numerical recipes constants
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 0 to 3 wait cycles from the top bits
    function automatic int unsigned pick_delay();
        lcg_state = lcg_next(lcg_state);
        return int'(lcg_state[31:30]);
    endfunction

    // memory contents for byte address a
    function automatic logic [31:0] mem_word(input fetch_pkg::addr_t a);
        return a ^ 32'h5a5a5a5a;
    endfunction

    // all outputs change on the falling edge
    initial begin
        int unsigned n;
        int unsigned beats;
        lcg_state = seed;
        arready   = 1'b0;
        r_beat    = '0;
        forever begin
            @(negedge aclk);
            if (!rst && ar_req.valid) begin
                n = pick_delay();
                repeat (n) @(negedge aclk);
                // request held stable until accepted
                burst_addr = ar_req.addr;
                burst_id   = ar_req.id;
                beats      = int'(ar_req.len) + 1;
                arready    = 1'b1;
                @(negedge aclk);
                arready = 1'b0;
                for (int i = 0; i < beats; i++) begin
                    n = pick_delay();
                    if (n != 0) begin
                        r_beat.valid = 1'b0;
                        repeat (n) @(negedge aclk);
                    end
                    r_beat.valid = 1'b1;
                    r_beat.id    = burst_id;
                    r_beat.data  = mem_word(burst_addr + 32'(4 * i));
                    r_beat.resp  = 2'b00;
                    r_beat.last  = (i == beats - 1);
                    // rready is stable here, so the beat moves on the next rising edge
                    while (rready !== 1'b1) begin
                        @(negedge aclk);
                    end
                    @(negedge aclk);
                end
                r_beat = '0;
            end
        end
    end

endmodule

// File: test/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

    localparam int line_words = 4;
    localparam int sets       = 16;
    localparam int num_rows   = 7;

    // optional redirect, hold length at the first fetch, fetches to check
    typedef struct packed {
        logic             jump;
        fetch_pkg::addr_t target;
        logic [7:0]       hold_cycles;
        logic [7:0]       fetches;
        logic             no_bus;
    } row_t;

    logic                  aclk = 1'b0;
    logic                  rst;
    logic                  hold;
    logic                  redirect;
    fetch_pkg::addr_t      redirect_pc;
    fetch_pkg::fetch_out_t fetch;
    axi_read_pkg::ar_req_t ar_req;
    logic                  arready;
    axi_read_pkg::r_beat_t r_beat;
    logic                  rready;

    row_t             rows [num_rows];
    fetch_pkg::addr_t exp_pc;
    int unsigned      errors      = 0;
    int unsigned      checks      = 0;
    int unsigned      ar_count    = 0;
    logic             table_ready = 1'b0;

    always #2 aclk = ~aclk;

    fetch_top #(
        .line_words (line_words),
        .sets       (sets)
    ) u_dut (
        .aclk        (aclk),
        .rst         (rst),
        .hold        (hold),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch       (fetch),
        .ar_req      (ar_req),
        .arready     (arready),
        .r_beat      (r_beat),
        .rready      (rready)
    );

    axi_mem_model u_mem (
        .aclk    (aclk),
        .rst     (rst),
        .ar_req  (ar_req),
        .arready (arready),
        .r_beat  (r_beat),
        .rready  (rready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // expected values and compares
    ////////////////////////////////////////////////////////////////////////////

    function automatic fetch_pkg::inst_t mem_word(input fetch_pkg::addr_t a);
        return a ^ 32'h5a5a5a5a;
    endfunction

    // line fill request for the pc that missed
    function automatic axi_read_pkg::ar_req_t expected_ar(input fetch_pkg::addr_t pc);
        axi_read_pkg::ar_req_t req;
        req.valid = 1'b1;
        req.id    = axi_read_pkg::fetch_id;
        req.addr  = pc & ~fetch_pkg::addr_t'(line_words * 4 - 1);
        req.len   = 8'(line_words - 1);
        req.size  = 3'b010;
        req.burst = 2'b01;
        return req;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("error: %s got %h expected %h", name, got, exp);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
            report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_fetch(input fetch_pkg::fetch_out_t got, input fetch_pkg::addr_t pc,
                               input fetch_pkg::inst_t inst);
        checks++;
        if (got.pc !== pc)
            report_mismatch("fetch.pc", got.pc, pc);
        if (got.inst !== inst)
            report_mismatch("fetch.inst", got.inst, inst);
    endtask

    task automatic check_ar(input axi_read_pkg::ar_req_t got, input axi_read_pkg::ar_req_t exp);
        checks++;
        if (got.valid !== exp.valid)
            report_mismatch("ar_req.valid", 32'(got.valid), 32'(exp.valid));
        if (got.id !== exp.id)
            report_mismatch("ar_req.id", 32'(got.id), 32'(exp.id));
        if (got.addr !== exp.addr)
            report_mismatch("ar_req.addr", got.addr, exp.addr);
        if (got.len !== exp.len)
            report_mismatch("ar_req.len", 32'(got.len), 32'(exp.len));
        if (got.size !== exp.size)
            report_mismatch("ar_req.size", 32'(got.size), 32'(exp.size));
        if (got.burst !== exp.burst)
            report_mismatch("ar_req.burst", 32'(got.burst), 32'(exp.burst));
    endtask

    task automatic wait_valid();
        while (fetch.valid !== 1'b1) begin
            @(negedge aclk);
        end
    endtask

    // address handshake, pre-edge values
    // the memory raises arready only for a request it saw, so valid must still be high
    always @(posedge aclk) begin
        if (!rst && arready) begin
            ar_count++;
            check_ar(ar_req, expected_ar(exp_pc));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table and main loop
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int unsigned row_errors;
        int unsigned row_bus;
        rst         = 1'b1;
        hold        = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        exp_pc      = 32'hbfc00000;
        rows[0] = '{1'b0, 32'h00000000, 8'd0, 8'd12, 1'b0};
        rows[1] = '{1'b1, 32'hbfc00000, 8'd0, 8'd8, 1'b1};
        // same set as the reset vector, other tag
        rows[2] = '{1'b1, 32'hbfc00100, 8'd0, 8'd6, 1'b0};
        rows[3] = '{1'b0, 32'h00000000, 8'd5, 8'd6, 1'b0};
        rows[4] = '{1'b1, 32'h80001234, 8'd3, 8'd10, 1'b0};
        rows[5] = '{1'b1, 32'h80001234, 8'd0, 8'd8, 1'b1};
        rows[6] = '{1'b1, 32'hbfc00000, 8'd2, 8'd5, 1'b0};
        table_ready = 1'b1;
        repeat (16) begin
            @(negedge aclk);
            check_flag("fetch.valid", fetch.valid, 1'b0);
            check_flag("ar_req.valid", ar_req.valid, 1'b0);
            check_flag("rready", rready, 1'b0);
        end
        rst = 1'b0;
        for (int r = 0; r < num_rows; r++) begin
            row_errors = errors;
            // redirect only on a hit, so the refill fsm is idle
            if (rows[r].jump) begin
                wait_valid();
                redirect    = 1'b1;
                redirect_pc = rows[r].target;
                exp_pc      = rows[r].target;
            end
            row_bus = ar_count;
            if (rows[r].jump) begin
                @(negedge aclk);
                redirect = 1'b0;
            end
            for (int k = 0; k < rows[r].fetches; k++) begin
                wait_valid();
                check_fetch(fetch, exp_pc, mem_word(exp_pc));
                if (k == 0 && rows[r].hold_cycles != 0) begin
                    hold = 1'b1;
                    repeat (rows[r].hold_cycles) begin
                        @(negedge aclk);
                        check_flag("fetch.valid", fetch.valid, 1'b1);
                        check_fetch(fetch, exp_pc, mem_word(exp_pc));
                    end
                    hold = 1'b0;
                end
                exp_pc += 4;
                @(negedge aclk);
            end
            row_bus = ar_count - row_bus;
            if (rows[r].no_bus && row_bus != 0) begin
                errors++;
                $display("row %0d: %0d read requests were issued for lines already cached",
                         r, row_bus);
            end
            $display("row %0d: %0d fetches, %0d hold cycles, %0d read requests, %s", r,
                     rows[r].fetches, rows[r].hold_cycles, row_bus,
                     (errors == row_errors) ? "ok" : "mismatch");
        end
        $display("summary: %0d rows, %0d checks, %0d errors", num_rows, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // about 40 cycles per fetch plus reset and slack
    initial begin
        int unsigned limit;
        wait (table_ready);
        limit = 1000;
        for (int r = 0; r < num_rows; r++) begin
            limit += rows[r].fetches * 40;
        end
        repeat (limit) @(posedge aclk);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: fetch_top.f
rtl/fetch_pkg.sv
rtl/axi_read_pkg.sv
rtl/pc_sequencer.sv
rtl/inst_cache.sv
rtl/refill_fsm.sv
rtl/beat_counter.sv
rtl/fetch_top.sv
test/axi_mem_model.sv
test/tb_fetch_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_fetch_top \
    -f fetch_top.f --Mdir obj_dir -o tb_fetch_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_fetch_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
